// ==== idct_block_top.f ====
+incdir+include
verilog/idct_pkg.sv
verilog/block_ram.sv
verilog/block_fetch.sv
verilog/idct_matrix_engine.sv
verilog/block_writeback.sv
verilog/idct_block_top.sv
test/tb_idct_block.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the IDCT block testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary -j 0 --top-module tb_idct_block -f idct_block_top.f -o tb_sim \
	> sim.log 2>&1 \
	&& ./obj_dir/tb_sim >> sim.log 2>&1 \
	|| echo "build or simulation did not complete" >> sim.log
cat sim.log
grep -q "^Testbench passed$" sim.log && echo "result: PASS" && exit 0 \
	|| { echo "result: FAIL"; exit 1; }

// ==== include/idct_tb_vectors.svh ====
// ------------------------------
// stimulus table for tb_idct_block
// columns: block kind, DC value,
// source word address, destination
// word address, chroma flag
// ------------------------------

`ifndef IDCT_TB_VECTORS_SVH
`define IDCT_TB_VECTORS_SVH

typedef enum logic [2:0] {
	KIND_ZERO,
	KIND_DC,    // only coefficient (0,0) set
	KIND_RAND,
	KIND_MAX,
	KIND_MIN
} blk_kind_e;

typedef struct packed {
	blk_kind_e kind;
	logic signed [15:0] dc;
	idct_pkg::sram_addr_t src;
	idct_pkg::sram_addr_t dst;
	logic chroma;
} vec_t;

localparam int NUM_VECS = 12;

// luma blocks side by side in a 320 wide plane, chroma in a 160 wide one
localparam vec_t VECS [NUM_VECS] = '{
	'{KIND_ZERO, 16'sd0,     18'h00000, 18'h20000, 1'b0},
	'{KIND_DC,   16'sd1024,  18'h00008, 18'h20004, 1'b0},
	'{KIND_RAND, 16'sd0,     18'h00010, 18'h20008, 1'b0},
	'{KIND_RAND, 16'sd0,     18'h00018, 18'h2000c, 1'b0},
	'{KIND_MAX,  16'sd0,     18'h00020, 18'h20010, 1'b0},
	'{KIND_MIN,  16'sd0,     18'h00028, 18'h20014, 1'b0},
	'{KIND_DC,   -16'sd200,  18'h10000, 18'h30000, 1'b1},
	'{KIND_RAND, 16'sd0,     18'h10008, 18'h30004, 1'b1},
	'{KIND_RAND, 16'sd0,     18'h10010, 18'h30008, 1'b1},
	'{KIND_RAND, 16'sd0,     18'h00a00, 18'h20500, 1'b0},    // second block row
	'{KIND_DC,   16'sd700,   18'h10500, 18'h30280, 1'b1},
	'{KIND_RAND, 16'sd0,     18'h00a08, 18'h20504, 1'b0}
};

`endif

// ==== test/tb_idct_block.sv ====
// ------------------------------
// testbench for idct_block_top
// clock, reset, SRAM model
// reference IDCT model, table loop
// write checks and watchdog
// ------------------------------

`timescale 1ns/1ns

module tb_idct_block;

	`include "idct_tb_vectors.svh"

	localparam int DIM = idct_pkg::BLOCK_DIM;
	localparam int LAT = idct_pkg::SRAM_READ_LATENCY;
	localparam int TIMEOUT_CYCLES = NUM_VECS * 2000;

	logic Clock;
	logic Resetn;
	logic req_valid_i;
	idct_pkg::idct_req_t req_i;
	logic req_credit_o;
	idct_pkg::sram_addr_t sram_rd_addr_o;
	idct_pkg::sram_word_t sram_rd_data_i = '0;
	idct_pkg::sram_addr_t sram_wr_addr_o;
	idct_pkg::sram_word_t sram_wr_data_o;
	logic sram_we_n_o;
	logic blk_done_o;

	idct_pkg::sram_word_t mem [idct_pkg::sram_addr_t];
	idct_pkg::sram_word_t rd_pipe [LAT] = '{default: '0};
	idct_pkg::sram_addr_t exp_addr_q [$];
	idct_pkg::sram_word_t exp_data_q [$];
	int coef [DIM][DIM];
	logic [7:0] pix [DIM][DIM];
	int value_errs = 0;
	int other_errs = 0;
	int req_cnt = 0;
	int credit_cnt = 0;
	int done_cnt = 0;
	int write_cnt = 0;
	logic mon_en = 1'b0;

	idct_block_top u_dut (
		.Clock          (Clock),
		.Resetn         (Resetn),
		.req_valid_i    (req_valid_i),
		.req_i          (req_i),
		.req_credit_o   (req_credit_o),
		.sram_rd_addr_o (sram_rd_addr_o),
		.sram_rd_data_i (sram_rd_data_i),
		.sram_wr_addr_o (sram_wr_addr_o),
		.sram_wr_data_o (sram_wr_data_o),
		.sram_we_n_o    (sram_we_n_o),
		.blk_done_o     (blk_done_o)
	);

	always #20 Clock = ~Clock;

	task automatic check_word(input string name, input idct_pkg::sram_word_t exp,
		input idct_pkg::sram_word_t act);
		if (act !== exp) begin
			$display("[FAIL] %0t ns %s: expected %h, got %h", $time, name, exp, act);
			value_errs++;
		end
	endtask

	task automatic check_addr(input string name, input idct_pkg::sram_addr_t exp,
		input idct_pkg::sram_addr_t act);
		if (act !== exp) begin
			$display("[FAIL] %0t ns %s: expected %h, got %h", $time, name, exp, act);
			value_errs++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("[FAIL] %0t ns %s: expected %0d, got %0d", $time, name, exp, act);
			value_errs++;
		end
	endtask

	task automatic check_idle_outputs();
		check_count("sram_we_n_o", 1, int'(sram_we_n_o));
		check_count("req_credit_o", 0, int'(req_credit_o));
		check_count("blk_done_o", 0, int'(blk_done_o));
	endtask

	// unwritten SRAM words, every address bit takes part
	function automatic idct_pkg::sram_word_t fill_word(input idct_pkg::sram_addr_t a);
		return idct_pkg::sram_word_t'(a ^ (a >> 5)) ^ 16'h9e37;
	endfunction

	function automatic logic [7:0] clip_byte(input int x);
		if (x < 0) begin
			return 8'd0;
		end else if (x > 255) begin
			return 8'd255;
		end
		return x[7:0];
	endfunction

	function automatic int coef_value(input vec_t v, input int r, input int c);
		if (v.kind == KIND_RAND) begin
			return int'($urandom_range(511)) - 256;
		end
		if (r != 0 || c != 0) begin
			return 0;
		end
		case (v.kind)
			KIND_DC:  return int'(v.dc);
			KIND_MAX: return 32767;
			KIND_MIN: return -32768;
			default:  return 0;
		endcase
	endfunction

	task automatic build_block(input vec_t v);
		idct_pkg::sram_addr_t stride;
		stride = v.chroma ? idct_pkg::SRC_STRIDE_UV : idct_pkg::SRC_STRIDE_Y;
		for (int r = 0; r < DIM; r++) begin
			for (int c = 0; c < DIM; c++) begin
				coef[r][c] = coef_value(v, r, c);
				mem[v.src + idct_pkg::sram_addr_t'(r) * stride + idct_pkg::sram_addr_t'(c)] =
					idct_pkg::sram_word_t'(coef[r][c]);
			end
		end
	endtask

	// T = S'C, then S = C^T T, 32 bit signed sums
	task automatic compute_pixels();
		int tmp [DIM][DIM];
		int acc;
		for (int r = 0; r < DIM; r++) begin
			for (int c = 0; c < DIM; c++) begin
				acc = 0;
				for (int k = 0; k < DIM; k++) begin
					acc += coef[r][k] * int'(idct_pkg::COS_TABLE[k][c]);
				end
				tmp[r][c] = acc >>> idct_pkg::PASS1_SHIFT;
			end
		end
		for (int r = 0; r < DIM; r++) begin
			for (int c = 0; c < DIM; c++) begin
				acc = 0;
				for (int k = 0; k < DIM; k++) begin
					acc += int'(idct_pkg::COS_TABLE[k][r]) * tmp[k][c];
				end
				pix[r][c] = clip_byte(acc >>> idct_pkg::PASS2_SHIFT);
			end
		end
	endtask

	task automatic push_expected(input vec_t v);
		idct_pkg::sram_addr_t stride;
		stride = v.chroma ? idct_pkg::DST_STRIDE_UV : idct_pkg::DST_STRIDE_Y;
		for (int r = 0; r < DIM; r++) begin
			for (int p = 0; p < DIM / 2; p++) begin
				exp_addr_q.push_back(v.dst + idct_pkg::sram_addr_t'(r) * stride
					+ idct_pkg::sram_addr_t'(p));
				exp_data_q.push_back({pix[r][2*p], pix[r][2*p+1]});    // even column high
			end
		end
	endtask

	task automatic send_request(input vec_t v);
		@(posedge Clock);
		while (idct_pkg::REQ_CREDITS + credit_cnt - req_cnt < 1) begin
			@(posedge Clock);
		end
		@(negedge Clock);
		req_i = '{src_addr: v.src, dst_addr: v.dst, chroma: v.chroma};
		req_valid_i = 1'b1;
		req_cnt++;
		@(negedge Clock);
		req_valid_i = 1'b0;
	endtask

	// read data shows up two cycles after its address
	always @(negedge Clock) begin
		sram_rd_data_i <= rd_pipe[LAT-1];
		for (int i = LAT - 1; i > 0; i--) begin
			rd_pipe[i] <= rd_pipe[i-1];
		end
		rd_pipe[0] <= mem.exists(sram_rd_addr_o) ? mem[sram_rd_addr_o] : fill_word(sram_rd_addr_o);
	end

	always @(negedge Clock) begin
		if (mon_en) begin
			if (!sram_we_n_o) begin
				if (exp_addr_q.size() == 0) begin
					$display("%0t ns: SRAM write to address %h while no write was expected",
						$time, sram_wr_addr_o);
					other_errs++;
				end else begin
					check_addr("sram_wr_addr_o", exp_addr_q.pop_front(), sram_wr_addr_o);
					check_word("sram_wr_data_o", exp_data_q.pop_front(), sram_wr_data_o);
				end
				write_cnt++;
			end
			if (req_credit_o) begin
				credit_cnt++;
			end
			if (blk_done_o) begin
				done_cnt++;
				check_count("writes before blk_done_o", done_cnt * 32, write_cnt);
			end
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge Clock);
		$display("timeout: only %0d of %0d blocks done after %0d cycles",
			done_cnt, NUM_VECS, TIMEOUT_CYCLES);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		Clock = 1'b0;
		Resetn = 1'b1;
		req_valid_i = 1'b0;
		req_i = '0;
		void'($urandom(32'hdae343ba));
		@(negedge Clock);
		Resetn = 1'b0;
		repeat (4) begin
			@(negedge Clock);
			check_idle_outputs();
		end
		Resetn = 1'b1;
		mon_en = 1'b1;
		repeat (3) begin
			@(negedge Clock);
			check_idle_outputs();
		end
		for (int v = 0; v < NUM_VECS; v++) begin
			build_block(VECS[v]);
			compute_pixels();
			push_expected(VECS[v]);
			send_request(VECS[v]);
		end
		while (done_cnt < NUM_VECS) begin
			@(posedge Clock);
		end
		repeat (20) @(negedge Clock);    // catch late stray writes
		check_count("req_credit_o pulses", NUM_VECS, credit_cnt);
		check_count("blk_done_o pulses", NUM_VECS, done_cnt);
		check_count("SRAM writes", NUM_VECS * 32, write_cnt);
		$display("%0d blocks, %0d value errors, %0d other errors",
			NUM_VECS, value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== verilog/idct_block_top.sv ====
// ----------------------------
// IDCT block subsystem top
// fetch, matrix engine, write-back
// sample and result buffers
// ----------------------------

`timescale 1ns/1ns

module idct_block_top (
	input  logic                 Clock,
	input  logic                 Resetn,
	input  logic                 req_valid_i,
	input  idct_pkg::idct_req_t  req_i,
	output logic                 req_credit_o,
	output idct_pkg::sram_addr_t sram_rd_addr_o,
	input  idct_pkg::sram_word_t sram_rd_data_i,
	output idct_pkg::sram_addr_t sram_wr_addr_o,
	output idct_pkg::sram_word_t sram_wr_data_o,
	output logic                 sram_we_n_o,
	output logic                 blk_done_o
);

	logic buf_wr_en, fetch_valid, sample_credit;
	logic result_valid, result_credit, result_wr_en;
	idct_pkg::buf_addr_t buf_wr_addr, sample_rd_addr, result_wr_addr, result_rd_addr;
	idct_pkg::sample_t buf_wr_data, sample_rd_data;
	idct_pkg::acc_t result_wr_data, result_rd_data;
	idct_pkg::idct_req_t fetch_req, result_req;

	block_fetch u_fetch (
		.Clock           (Clock),
		.Resetn          (Resetn),
		.req_valid_i     (req_valid_i),
		.req_i           (req_i),
		.req_credit_o    (req_credit_o),
		.sram_rd_addr_o  (sram_rd_addr_o),
		.sram_rd_data_i  (sram_rd_data_i),
		.buf_wr_en_o     (buf_wr_en),
		.buf_wr_addr_o   (buf_wr_addr),
		.buf_wr_data_o   (buf_wr_data),
		.fetch_valid_o   (fetch_valid),
		.fetch_req_o     (fetch_req),
		.sample_credit_i (sample_credit)
	);

	block_ram #(
		.word_t(idct_pkg::sample_t)
	) u_sample_buf (
		.Clock     (Clock),
		.wr_en_i   (buf_wr_en),
		.wr_addr_i (buf_wr_addr),
		.wr_data_i (buf_wr_data),
		.rd_addr_i (sample_rd_addr),
		.rd_data_o (sample_rd_data)
	);

	idct_matrix_engine u_engine (
		.Clock            (Clock),
		.Resetn           (Resetn),
		.fetch_valid_i    (fetch_valid),
		.fetch_req_i      (fetch_req),
		.sample_credit_o  (sample_credit),
		.sample_rd_addr_o (sample_rd_addr),
		.sample_rd_data_i (sample_rd_data),
		.result_valid_o   (result_valid),
		.result_req_o     (result_req),
		.result_credit_i  (result_credit),
		.result_wr_en_o   (result_wr_en),
		.result_wr_addr_o (result_wr_addr),
		.result_wr_data_o (result_wr_data)
	);

	block_ram #(
		.word_t(idct_pkg::acc_t)
	) u_result_buf (
		.Clock     (Clock),
		.wr_en_i   (result_wr_en),
		.wr_addr_i (result_wr_addr),
		.wr_data_i (result_wr_data),
		.rd_addr_i (result_rd_addr),
		.rd_data_o (result_rd_data)
	);

	block_writeback u_writeback (
		.Clock            (Clock),
		.Resetn           (Resetn),
		.result_valid_i   (result_valid),
		.result_req_i     (result_req),
		.result_credit_o  (result_credit),
		.result_rd_addr_o (result_rd_addr),
		.result_rd_data_i (result_rd_data),
		.sram_wr_addr_o   (sram_wr_addr_o),
		.sram_wr_data_o   (sram_wr_data_o),
		.sram_we_n_o      (sram_we_n_o),
		.blk_done_o       (blk_done_o)
	);

endmodule

// ==== verilog/block_writeback.sv ====
// ----------------------------
// write-back stage
// clips results to 8 bits, packs
// pixel pairs, writes rows to SRAM
// ----------------------------

`timescale 1ns/1ns

module block_writeback (
	input  logic                 Clock,
	input  logic                 Resetn,
	input  logic                 result_valid_i,
	input  idct_pkg::idct_req_t  result_req_i,
	output logic                 result_credit_o,
	output idct_pkg::buf_addr_t  result_rd_addr_o,
	input  idct_pkg::acc_t       result_rd_data_i,
	output idct_pkg::sram_addr_t sram_wr_addr_o,
	output idct_pkg::sram_word_t sram_wr_data_o,
	output logic                 sram_we_n_o,
	output logic                 blk_done_o
);

	typedef enum logic [1:0] {S_IDLE, S_RUN, S_TAIL, S_DONE} state_t;

	state_t state;
	logic pend, vld_q;
	idct_pkg::idct_req_t cur_req;
	idct_pkg::buf_addr_t rd_cnt, idx_q;
	idct_pkg::sram_addr_t stride;
	logic [7:0] hi_byte, lo_byte;

	function automatic logic [7:0] clip_pixel(input idct_pkg::acc_t v);
		if (v < 0) begin
			return 8'd0;
		end
		if (v > 255) begin
			return 8'd255;
		end
		return v[7:0];
	endfunction

	assign result_rd_addr_o = rd_cnt;
	assign stride = cur_req.chroma ? idct_pkg::DST_STRIDE_UV : idct_pkg::DST_STRIDE_Y;
	assign lo_byte = clip_pixel(result_rd_data_i);

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= S_IDLE;
			pend <= 1'b0;
			vld_q <= 1'b0;
			rd_cnt <= '0;
			result_credit_o <= 1'b0;
			blk_done_o <= 1'b0;
			sram_we_n_o <= 1'b1;
			sram_wr_addr_o <= '0;
			sram_wr_data_o <= '0;
		end else begin
			result_credit_o <= 1'b0;
			blk_done_o <= 1'b0;
			sram_we_n_o <= 1'b1;
			vld_q <= (state == S_RUN);
			case (state)
				S_IDLE: begin
					if (pend) begin
						pend <= 1'b0;
						state <= S_RUN;
					end
				end
				S_RUN: begin
					rd_cnt <= rd_cnt + 6'd1;
					if (rd_cnt == 6'd63) begin
						state <= S_TAIL;
					end
				end
				S_TAIL: begin
					result_credit_o <= 1'b1;    // buffer fully read
					state <= S_DONE;
				end
				S_DONE: begin
					blk_done_o <= 1'b1;
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
			// odd column completes the pair
			if (vld_q && idx_q[0]) begin
				sram_we_n_o <= 1'b0;
				sram_wr_addr_o <= cur_req.dst_addr
					+ idct_pkg::sram_addr_t'(idx_q[5:3]) * stride
					+ idct_pkg::sram_addr_t'(idx_q[2:1]);
				sram_wr_data_o <= {hi_byte, lo_byte};
			end
			if (result_valid_i) begin
				pend <= 1'b1;
			end
		end
	end

	always_ff @(posedge Clock) begin
		idx_q <= rd_cnt;
		if (result_valid_i) begin
			cur_req <= result_req_i;
		end
		if (vld_q && !idx_q[0]) begin
			hi_byte <= lo_byte;    // even column, high byte
		end
	end

endmodule

// ==== verilog/idct_matrix_engine.sv ====
// ----------------------------
// IDCT matrix engine
// pass 1 T = S'C into the T buffer
// pass 2 S = C^T T into the result buffer
// two MAC lanes, one FSM
// ----------------------------

`timescale 1ns/1ns

module idct_matrix_engine (
	input  logic                 Clock,
	input  logic                 Resetn,
	input  logic                 fetch_valid_i,
	input  idct_pkg::idct_req_t  fetch_req_i,
	output logic                 sample_credit_o,
	output idct_pkg::buf_addr_t  sample_rd_addr_o,
	input  idct_pkg::sample_t    sample_rd_data_i,
	output logic                 result_valid_o,
	output idct_pkg::idct_req_t  result_req_o,
	input  logic                 result_credit_i,
	output logic                 result_wr_en_o,
	output idct_pkg::buf_addr_t  result_wr_addr_o,
	output idct_pkg::acc_t       result_wr_data_o
);

	typedef enum logic [2:0] {S_IDLE, S_LOAD, S_MAC, S_WAIT_RES, S_DONE} state_t;

	state_t state;
	logic pass, pend, res_credit, t_wr_en, mac_last;
	logic [2:0] vec, o_idx;    // operand vector, output index
	logic [3:0] ld_cnt;
	logic [1:0] step;
	idct_pkg::idct_req_t pend_req, cur_req;
	idct_pkg::buf_addr_t rd_addr, wr_addr;
	idct_pkg::acc_t opnd [idct_pkg::BLOCK_DIM];
	idct_pkg::acc_t t_rd_data, opnd_in, acc, p0, p1, sum, wr_data;

	block_ram #(
		.word_t(idct_pkg::acc_t)
	) u_t_buf (
		.Clock     (Clock),
		.wr_en_i   (t_wr_en),
		.wr_addr_i (wr_addr),
		.wr_data_i (wr_data),
		.rd_addr_i (rd_addr),
		.rd_data_o (t_rd_data)
	);

	// pass 1 walks rows of S', pass 2 walks columns of T
	assign rd_addr = pass ? {ld_cnt[2:0], vec} : {vec, ld_cnt[2:0]};
	assign sample_rd_addr_o = rd_addr;
	assign opnd_in = pass ? t_rd_data : idct_pkg::acc_t'(sample_rd_data_i);
	assign mac_last = (state == S_MAC) && (step == 2'd3);

	assign result_wr_addr_o = wr_addr;
	assign result_wr_data_o = wr_data;
	assign result_req_o = cur_req;

	// lane 0 takes the even k, lane 1 the odd k
	always_comb begin
		p0 = opnd[{step, 1'b0}] *
			idct_pkg::acc_t'(idct_pkg::COS_TABLE[{step, 1'b0}][o_idx]);
		p1 = opnd[{step, 1'b1}] *
			idct_pkg::acc_t'(idct_pkg::COS_TABLE[{step, 1'b1}][o_idx]);
		sum = ((step == 2'd0) ? idct_pkg::acc_t'(0) : acc) + p0 + p1;
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= S_IDLE;
			pass <= 1'b0;
			pend <= 1'b0;
			res_credit <= 1'b1;
			vec <= 3'd0;
			o_idx <= 3'd0;
			ld_cnt <= 4'd0;
			step <= 2'd0;
			t_wr_en <= 1'b0;
			result_wr_en_o <= 1'b0;
			sample_credit_o <= 1'b0;
			result_valid_o <= 1'b0;
		end else begin
			sample_credit_o <= 1'b0;
			result_valid_o <= 1'b0;
			t_wr_en <= mac_last && !pass;
			result_wr_en_o <= mac_last && pass;
			case (state)
				S_IDLE: begin
					if (pend) begin
						pend <= 1'b0;
						pass <= 1'b0;
						state <= S_LOAD;
					end
				end
				S_LOAD: begin
					ld_cnt <= ld_cnt + 4'd1;
					if (ld_cnt == 4'd8) begin
						ld_cnt <= 4'd0;
						state <= S_MAC;
						if (!pass && vec == 3'd7) begin
							sample_credit_o <= 1'b1;    // last row of S' is in
						end
					end
				end
				S_MAC: begin
					step <= step + 2'd1;
					if (step == 2'd3) begin
						o_idx <= o_idx + 3'd1;
						if (o_idx == 3'd7) begin
							vec <= vec + 3'd1;
							if (vec != 3'd7) begin
								state <= S_LOAD;
							end else if (!pass) begin
								state <= S_WAIT_RES;
							end else begin
								state <= S_DONE;
							end
						end
					end
				end
				S_WAIT_RES: begin
					if (res_credit) begin
						res_credit <= 1'b0;
						pass <= 1'b1;
						state <= S_LOAD;
					end
				end
				S_DONE: begin
					result_valid_o <= 1'b1;    // last result lands this cycle
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
			if (fetch_valid_i) begin
				pend <= 1'b1;
			end
			if (result_credit_i) begin
				res_credit <= 1'b1;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (fetch_valid_i) begin
			pend_req <= fetch_req_i;
		end
		if (state == S_IDLE && pend) begin
			cur_req <= pend_req;
		end
		if (state == S_LOAD && ld_cnt != 4'd0) begin
			for (int k = 0; k < idct_pkg::BLOCK_DIM - 1; k++) begin
				opnd[k] <= opnd[k+1];
			end
			opnd[idct_pkg::BLOCK_DIM-1] <= opnd_in;
		end
		if (state == S_MAC) begin
			acc <= sum;
		end
		if (mac_last) begin
			wr_addr <= pass ? {o_idx, vec} : {vec, o_idx};
			wr_data <= pass ? (sum >>> idct_pkg::PASS2_SHIFT) : (sum >>> idct_pkg::PASS1_SHIFT);
		end
	end

endmodule

// ==== verilog/block_fetch.sv ====
// ----------------------------
// block fetch stage
// reads 64 coefficients from SRAM
// into the sample buffer, credit based
// ----------------------------

`timescale 1ns/1ns

module block_fetch (
	input  logic                 Clock,
	input  logic                 Resetn,
	input  logic                 req_valid_i,
	input  idct_pkg::idct_req_t  req_i,
	output logic                 req_credit_o,
	output idct_pkg::sram_addr_t sram_rd_addr_o,
	input  idct_pkg::sram_word_t sram_rd_data_i,
	output logic                 buf_wr_en_o,
	output idct_pkg::buf_addr_t  buf_wr_addr_o,
	output idct_pkg::sample_t    buf_wr_data_o,
	output logic                 fetch_valid_o,
	output idct_pkg::idct_req_t  fetch_req_o,
	input  logic                 sample_credit_i
);

	typedef enum logic [1:0] {S_IDLE, S_READ, S_DRAIN} state_t;

	typedef struct packed {
		logic vld;
		idct_pkg::buf_addr_t idx;
	} tag_t;

	state_t state;
	tag_t tag_q [idct_pkg::SRAM_READ_LATENCY];
	tag_t tag_out;
	idct_pkg::idct_req_t pend_req, cur_req, next_req;
	idct_pkg::sram_addr_t row_base, stride;
	logic [2:0] row, col;
	logic pend, smp_credit, start, store;

	assign next_req = pend ? pend_req : req_i;
	assign start = (state == S_IDLE) && smp_credit && (pend || req_valid_i);
	// keep a request unless it goes straight in; one arriving on a full slot is dropped
	assign store = req_valid_i && (pend == start);
	assign stride = cur_req.chroma ? idct_pkg::SRC_STRIDE_UV : idct_pkg::SRC_STRIDE_Y;

	assign tag_out = tag_q[idct_pkg::SRAM_READ_LATENCY-1];
	assign buf_wr_en_o = tag_out.vld;
	assign buf_wr_addr_o = tag_out.idx;
	assign buf_wr_data_o = idct_pkg::sample_t'(sram_rd_data_i);
	assign fetch_req_o = cur_req;

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= S_IDLE;
			pend <= 1'b0;
			smp_credit <= 1'b1;
			row <= 3'd0;
			col <= 3'd0;
			row_base <= '0;
			sram_rd_addr_o <= '0;
			req_credit_o <= 1'b0;
			fetch_valid_o <= 1'b0;
			for (int i = 0; i < idct_pkg::SRAM_READ_LATENCY; i++) begin
				tag_q[i] <= '0;
			end
		end else begin
			req_credit_o <= 1'b0;
			fetch_valid_o <= 1'b0;
			// index follows its word through the read latency
			tag_q[0] <= '{vld: (state == S_READ), idx: {row, col}};
			for (int i = 1; i < idct_pkg::SRAM_READ_LATENCY; i++) begin
				tag_q[i] <= tag_q[i-1];
			end
			if (start || store) begin
				pend <= store;
			end
			case (state)
				S_IDLE: begin
					if (start) begin
						smp_credit <= 1'b0;
						row_base <= next_req.src_addr;
						sram_rd_addr_o <= next_req.src_addr;
						state <= S_READ;
					end
				end
				S_READ: begin
					col <= col + 3'd1;
					if (col == 3'd7) begin
						row <= row + 3'd1;
						row_base <= row_base + stride;    // next line
						sram_rd_addr_o <= row_base + stride;
						if (row == 3'd7) begin
							state <= S_DRAIN;
						end
					end else begin
						sram_rd_addr_o <= sram_rd_addr_o + 18'd1;
					end
				end
				S_DRAIN: begin
					if (tag_out.vld && tag_out.idx == 6'd63) begin
						fetch_valid_o <= 1'b1;
						req_credit_o <= 1'b1;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
			if (sample_credit_i) begin
				smp_credit <= 1'b1;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (store) begin
			pend_req <= req_i;
		end
		if (start) begin
			cur_req <= next_req;
		end
	end

endmodule

// ==== verilog/block_ram.sv ====
// ----------------------------
// block buffer, 64 words
// one write port, one registered read port
// ----------------------------

`timescale 1ns/1ns

module block_ram #(
	parameter type word_t = logic [15:0]
) (
	input  logic                Clock,
	input  logic                wr_en_i,
	input  idct_pkg::buf_addr_t wr_addr_i,
	input  word_t               wr_data_i,
	input  idct_pkg::buf_addr_t rd_addr_i,
	output word_t               rd_data_o
);

	word_t mem [idct_pkg::BLOCK_WORDS];

	always_ff @(posedge Clock) begin
		if (wr_en_i) begin
			mem[wr_addr_i] <= wr_data_i;
		end
		rd_data_o <= mem[rd_addr_i];    // old data on same-address write
	end

endmodule

// ==== verilog/idct_pkg.sv ====
// ----------------------------
// inverse DCT block package
// widths, request struct, strides
// cosine table and shift amounts
// ----------------------------

package idct_pkg;

	typedef logic [17:0] sram_addr_t;
	typedef logic [15:0] sram_word_t;
	typedef logic signed [15:0] sample_t;
	typedef logic signed [31:0] acc_t;
	typedef logic [5:0] buf_addr_t;    // row in [5:3], column in [2:0]

	typedef struct packed {
		sram_addr_t src_addr;    // first coefficient word
		sram_addr_t dst_addr;    // first pixel word
		logic chroma;
	} idct_req_t;

	localparam int BLOCK_DIM = 8;
	localparam int BLOCK_WORDS = BLOCK_DIM * BLOCK_DIM;

	// line strides in words
	localparam sram_addr_t SRC_STRIDE_Y = 18'd320;
	localparam sram_addr_t SRC_STRIDE_UV = 18'd160;
	localparam sram_addr_t DST_STRIDE_Y = 18'd160;
	localparam sram_addr_t DST_STRIDE_UV = 18'd80;

	// row is the frequency index, column the spatial index, scaled by 2^12
	localparam logic signed [15:0] COS_TABLE [BLOCK_DIM][BLOCK_DIM] = '{
		'{16'sd1448, 16'sd1448, 16'sd1448, 16'sd1448,
			16'sd1448, 16'sd1448, 16'sd1448, 16'sd1448},
		'{16'sd2009, 16'sd1703, 16'sd1138, 16'sd399,
			-16'sd399, -16'sd1138, -16'sd1703, -16'sd2009},
		'{16'sd1892, 16'sd784, -16'sd784, -16'sd1892,
			-16'sd1892, -16'sd784, 16'sd784, 16'sd1892},
		'{16'sd1703, -16'sd399, -16'sd2009, -16'sd1138,
			16'sd1138, 16'sd2009, 16'sd399, -16'sd1703},
		'{16'sd1448, -16'sd1448, -16'sd1448, 16'sd1448,
			16'sd1448, -16'sd1448, -16'sd1448, 16'sd1448},
		'{16'sd1138, -16'sd2009, 16'sd399, 16'sd1703,
			-16'sd1703, -16'sd399, 16'sd2009, -16'sd1138},
		'{16'sd784, -16'sd1892, 16'sd1892, -16'sd784,
			-16'sd784, 16'sd1892, -16'sd1892, 16'sd784},
		'{16'sd399, -16'sd1138, 16'sd1703, -16'sd2009,
			16'sd2009, -16'sd1703, 16'sd1138, -16'sd399}
	};

	// T keeps 4 fraction bits, S comes out as an integer
	localparam int PASS1_SHIFT = 8;
	localparam int PASS2_SHIFT = 16;

	localparam int SRAM_READ_LATENCY = 2;
	localparam int REQ_CREDITS = 1;

endpackage
